//--- common/iis_params.svh
`ifndef IIS_PARAMS_SVH
`define IIS_PARAMS_SVH

// Bits per channel word
`define IIS_DATA_SIZE 16

// clk_i cycles per bit clock half period
`define IIS_BCLK_HALF 8

// clk_i cycles per word clock half period
// One channel half holds exactly IIS_DATA_SIZE bit clock periods,
// so word clock edges land on bit clock falling edges
`define IIS_LRCLK_HALF (`IIS_DATA_SIZE * 2 * `IIS_BCLK_HALF)

// Bit counter width, must hold IIS_DATA_SIZE itself
`define IIS_BCNT_W 5

`endif

//--- common/iis_pkg.sv
`include "iis_params.svh"

package iis_pkg;

  // One channel sample
  typedef logic [`IIS_DATA_SIZE-1:0] sample_t;

  // Bit position within a channel half
  typedef logic [`IIS_BCNT_W-1:0] bit_cnt_t;

  // Frame half a word belongs to
  // Low word clock is the left channel
  typedef enum logic {
    chan_left  = 1'b0,
    chan_right = 1'b1
  } chan_t;

  // Receiver FSM
  typedef enum logic {
    idle_wait = 1'b0,  // waiting for first word clock edge
    shifting  = 1'b1
  } rx_state_t;

endpackage

//--- logic/iis_clock_gen.sv
`timescale 1ns/1ns
`include "iis_params.svh"

module iis_clock_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic ac_mclk,
  output logic ac_bclk,
  output logic ac_lrclk,
  output logic bclk_rise,
  output logic bclk_fall,
  output logic lrclk_rise,
  output logic lrclk_fall
);

  localparam int unsigned bclk_cnt_w  = $clog2(`IIS_BCLK_HALF);
  localparam int unsigned lrclk_cnt_w = $clog2(`IIS_LRCLK_HALF);

  // Counters run down to zero, then reload
  localparam logic [bclk_cnt_w-1:0]  bclk_reload  = bclk_cnt_w'(`IIS_BCLK_HALF - 1);
  localparam logic [lrclk_cnt_w-1:0] lrclk_reload = lrclk_cnt_w'(`IIS_LRCLK_HALF - 1);

  logic [bclk_cnt_w-1:0]  bclk_cnt;
  logic [lrclk_cnt_w-1:0] lrclk_cnt;
  logic                   bclk_zero;
  logic                   lrclk_zero;

  // Master clock, half of clk_i
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ac_mclk <= 1'b0;
    end else begin
      ac_mclk <= ~ac_mclk;
    end
  end

  // Bit clock divider
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_cnt <= bclk_reload;
      ac_bclk  <= 1'b0;
    end else if (bclk_zero) begin
      bclk_cnt <= bclk_reload;
      ac_bclk  <= ~ac_bclk;
    end else begin
      bclk_cnt <= bclk_cnt - 1'b1;
    end
  end

  // Word clock divider
  // Same start value as bit divider scaled up, so edges stay aligned
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lrclk_cnt <= lrclk_reload;
      ac_lrclk  <= 1'b0;
    end else if (lrclk_zero) begin
      lrclk_cnt <= lrclk_reload;
      ac_lrclk  <= ~ac_lrclk;
    end else begin
      lrclk_cnt <= lrclk_cnt - 1'b1;
    end
  end

  assign bclk_zero  = (bclk_cnt == '0);
  assign lrclk_zero = (lrclk_cnt == '0);

  // Strobes fire in the cycle before the toggle
  // Edge direction from current clock level
  assign bclk_rise  = bclk_zero & ~ac_bclk;
  assign bclk_fall  = bclk_zero & ac_bclk;
  assign lrclk_rise = lrclk_zero & ~ac_lrclk;
  assign lrclk_fall = lrclk_zero & ac_lrclk;

endmodule

//--- logic/iis_play_buffer.sv
`timescale 1ns/1ns

module iis_play_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              play_valid,
  input  logic              lrclk_fall,
  input  iis_pkg::sample_t  play_left,
  input  iis_pkg::sample_t  play_right,
  output iis_pkg::sample_t  tx_left,
  output iis_pkg::sample_t  tx_right,
  output logic              play_taken
);

  iis_pkg::sample_t pend_left;
  iis_pkg::sample_t pend_right;
  logic             pend_vld;
  iis_pkg::sample_t tx_left_q;
  iis_pkg::sample_t tx_right_q;
  logic             take;

  // Hand over only at frame start and only if something waits
  assign take = lrclk_fall & pend_vld;

  // Pending pair, newest write wins
  always_ff @(posedge clk_i) begin
    if (play_valid) begin
      pend_left  <= play_left;
      pend_right <= play_right;
    end
  end

  // A write in the handover cycle stays pending for the next frame
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_vld <= 1'b0;
    end else if (play_valid) begin
      pend_vld <= 1'b1;
    end else if (lrclk_fall) begin
      pend_vld <= 1'b0;
    end
  end

  // Transmit pair, kept over frames with no new data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_left_q  <= '0;
      tx_right_q <= '0;
      play_taken <= 1'b0;
    end else begin
      play_taken <= take;
      if (take) begin
        tx_left_q  <= pend_left;
        tx_right_q <= pend_right;
      end
    end
  end

  // Bypass so the shifter loads the new left word in the handover cycle
  assign tx_left  = take ? pend_left : tx_left_q;
  assign tx_right = take ? pend_right : tx_right_q;

endmodule

//--- iis_serdes/iis_tx_shift.sv
`timescale 1ns/1ns
`include "iis_params.svh"

module iis_tx_shift (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             bclk_fall,
  input  logic             lrclk_rise,
  input  logic             lrclk_fall,
  input  iis_pkg::sample_t tx_left,
  input  iis_pkg::sample_t tx_right,
  output logic             ac_sdout
);

  localparam int unsigned msb = `IIS_DATA_SIZE - 1;

  iis_pkg::sample_t shreg;
  iis_pkg::sample_t next_word;
  logic             reload;

  // Word clock strobes always sit on a bit clock fall
  assign reload = lrclk_rise | lrclk_fall;

  // Left half starts at falling word clock
  assign next_word = lrclk_fall ? tx_left : tx_right;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shreg    <= '0;
      ac_sdout <= 1'b0;
    end else if (bclk_fall) begin
      // Old word's LSB still goes out on the edge itself
      ac_sdout <= shreg[msb];
      if (reload) begin
        shreg <= next_word;
      end else begin
        shreg <= {shreg[msb-1:0], 1'b0};
      end
    end
  end

  // MSB goes out one bit clock after the word clock edge,
  // LSB on the fall of the following word clock edge

endmodule

//--- iis_serdes/iis_rx_shift.sv
`timescale 1ns/1ns
`include "iis_params.svh"

module iis_rx_shift (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              bclk_rise,
  input  logic              lrclk_rise,
  input  logic              lrclk_fall,
  input  logic              ac_sdin,
  output iis_pkg::sample_t  rx_word,
  output iis_pkg::chan_t    rx_chan,
  output logic              word_done
);

  localparam iis_pkg::bit_cnt_t bits_full = iis_pkg::bit_cnt_t'(`IIS_DATA_SIZE);
  localparam iis_pkg::bit_cnt_t bits_last = iis_pkg::bit_cnt_t'(`IIS_DATA_SIZE - 1);

  iis_pkg::rx_state_t state;
  iis_pkg::bit_cnt_t  bit_cnt;
  iis_pkg::sample_t   shreg;
  logic               lr_edge;
  logic               take_bit;

  assign lr_edge = lrclk_rise | lrclk_fall;

  // Only the first DATA_SIZE rises of a half carry data
  assign take_bit = (state == iis_pkg::shifting) & bclk_rise & (bit_cnt != bits_full);

  // FSM and bit counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state     <= iis_pkg::idle_wait;
      bit_cnt   <= '0;
      rx_chan   <= iis_pkg::chan_left;
      word_done <= 1'b0;
    end else begin
      // Pulse lands the cycle after the last sampling rise
      word_done <= take_bit & (bit_cnt == bits_last);
      if (lr_edge) begin
        // First edge after reset starts sampling
        state   <= iis_pkg::shifting;
        bit_cnt <= '0;
        rx_chan <= lrclk_fall ? iis_pkg::chan_left : iis_pkg::chan_right;
      end else if (take_bit) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Data shifts in MSB first
  always_ff @(posedge clk_i) begin
    if (take_bit) begin
      shreg <= {shreg[`IIS_DATA_SIZE-2:0], ac_sdin};
    end
  end

  // Word holds still until the next half starts sampling
  assign rx_word = shreg;

endmodule

//--- logic/iis_rec_output.sv
`timescale 1ns/1ns

module iis_rec_output (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              word_done,
  input  iis_pkg::sample_t  rx_word,
  input  iis_pkg::chan_t    rx_chan,
  output iis_pkg::sample_t  rec_left,
  output iis_pkg::sample_t  rec_right,
  output logic              rec_valid
);

  iis_pkg::sample_t left_q;
  logic             have_left;
  logic             got_left;
  logic             publish;

  assign got_left = word_done & (rx_chan == iis_pkg::chan_left);

  // Right word completes a pair only after a stored left word
  assign publish = word_done & (rx_chan == iis_pkg::chan_right) & have_left;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      have_left <= 1'b0;
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= publish;
      if (got_left) begin
        have_left <= 1'b1;
      end else if (publish) begin
        have_left <= 1'b0;
      end
    end
  end

  // Left word waits for its partner
  always_ff @(posedge clk_i) begin
    if (got_left) begin
      left_q <= rx_word;
    end
  end

  // No back-pressure, next pair overwrites
  always_ff @(posedge clk_i) begin
    if (publish) begin
      rec_left  <= left_q;
      rec_right <= rx_word;
    end
  end

endmodule

//--- logic/iis_codec_top.sv
`timescale 1ns/1ns

module iis_codec_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              play_valid,
  input  iis_pkg::sample_t  play_left,
  input  iis_pkg::sample_t  play_right,
  output logic              play_taken,
  output logic              ac_mclk,
  output logic              ac_bclk,
  output logic              ac_lrclk,
  output logic              ac_sdout,
  input  logic              ac_sdin,
  output iis_pkg::sample_t  rec_left,
  output iis_pkg::sample_t  rec_right,
  output logic              rec_valid
);

  // Strobes from the clock generator
  logic bclk_rise;
  logic bclk_fall;
  logic lrclk_rise;
  logic lrclk_fall;

  // Playback path
  iis_pkg::sample_t tx_left;
  iis_pkg::sample_t tx_right;

  // Recording path
  iis_pkg::sample_t rx_word;
  iis_pkg::chan_t   rx_chan;
  logic             word_done;

  iis_clock_gen u_clock_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ac_mclk    (ac_mclk),
    .ac_bclk    (ac_bclk),
    .ac_lrclk   (ac_lrclk),
    .bclk_rise  (bclk_rise),
    .bclk_fall  (bclk_fall),
    .lrclk_rise (lrclk_rise),
    .lrclk_fall (lrclk_fall)
  );

  iis_play_buffer u_play_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .play_valid (play_valid),
    .lrclk_fall (lrclk_fall),
    .play_left  (play_left),
    .play_right (play_right),
    .tx_left    (tx_left),
    .tx_right   (tx_right),
    .play_taken (play_taken)
  );

  iis_tx_shift u_tx_shift (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bclk_fall  (bclk_fall),
    .lrclk_rise (lrclk_rise),
    .lrclk_fall (lrclk_fall),
    .tx_left    (tx_left),
    .tx_right   (tx_right),
    .ac_sdout   (ac_sdout)
  );

  iis_rx_shift u_rx_shift (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bclk_rise  (bclk_rise),
    .lrclk_rise (lrclk_rise),
    .lrclk_fall (lrclk_fall),
    .ac_sdin    (ac_sdin),
    .rx_word    (rx_word),
    .rx_chan    (rx_chan),
    .word_done  (word_done)
  );

  iis_rec_output u_rec_output (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .word_done  (word_done),
    .rx_word    (rx_word),
    .rx_chan    (rx_chan),
    .rec_left   (rec_left),
    .rec_right  (rec_right),
    .rec_valid  (rec_valid)
  );

endmodule

//--- tb/iis_codec_props.sv
`timescale 1ns/1ns

module iis_codec_props (
  input logic clk_i,
  input logic rst_ni,
  input logic bclk_rise,
  input logic bclk_fall,
  input logic lrclk_rise,
  input logic lrclk_fall,
  input logic play_taken,
  input logic rec_valid
);

  // Each strobe lasts one cycle
  a_bclk_rise_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_rise |=> !bclk_rise) else $error("bclk_rise high for two cycles");
  a_bclk_fall_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_fall |=> !bclk_fall) else $error("bclk_fall high for two cycles");
  a_lrclk_rise_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lrclk_rise |=> !lrclk_rise) else $error("lrclk_rise high for two cycles");
  a_lrclk_fall_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lrclk_fall |=> !lrclk_fall) else $error("lrclk_fall high for two cycles");

  // Word clock edges sit on bit clock falls
  a_lr_on_bfall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lrclk_rise | lrclk_fall) |-> bclk_fall) else $error("lrclk strobe without bclk_fall");

  // A bit clock rise never carries a word clock edge
  a_rise_fall_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bclk_rise && (lrclk_rise || lrclk_fall))) else $error("lrclk strobe on a bclk rise");

  a_rec_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_valid |=> !rec_valid) else $error("rec_valid high for two cycles");
  a_taken_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    play_taken |=> !play_taken) else $error("play_taken high for two cycles");

endmodule

bind iis_codec_top iis_codec_props u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .bclk_rise  (bclk_rise),
  .bclk_fall  (bclk_fall),
  .lrclk_rise (lrclk_rise),
  .lrclk_fall (lrclk_fall),
  .play_taken (play_taken),
  .rec_valid  (rec_valid)
);

//--- tb/iis_codec_tb.sv
`timescale 1ns/1ns
`include "iis_params.svh"

module iis_codec_tb;

  localparam int unsigned cycle_limit = 40000;

  logic             clk_i;
  logic             rst_ni;
  logic             play_valid;
  iis_pkg::sample_t play_left;
  iis_pkg::sample_t play_right;
  logic             play_taken;
  logic             ac_mclk;
  logic             ac_bclk;
  logic             ac_lrclk;
  logic             ac_sdout;
  logic             ac_sdin;
  iis_pkg::sample_t rec_left;
  iis_pkg::sample_t rec_right;
  logic             rec_valid;

  logic             loop_en;
  logic             model_run;
  logic             model_sdin;
  logic             model_hl;
  logic             prev_bclk;
  logic             prev_lr;
  iis_pkg::sample_t model_sh;
  iis_pkg::sample_t model_l;
  logic [31:0]      lfsr;
  logic [31:0]      exp_q[$];
  int unsigned      cycles;
  int unsigned      taken_cnt;
  // Right word sent in the frame before the current one
  iis_pkg::sample_t last_right;

  iis_codec_top uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .play_valid (play_valid),
    .play_left  (play_left),
    .play_right (play_right),
    .play_taken (play_taken),
    .ac_mclk    (ac_mclk),
    .ac_bclk    (ac_bclk),
    .ac_lrclk   (ac_lrclk),
    .ac_sdout   (ac_sdout),
    .ac_sdin    (ac_sdin),
    .rec_left   (rec_left),
    .rec_right  (rec_right),
    .rec_valid  (rec_valid)
  );

  always #20 clk_i = ~clk_i;

  // Serial input either looped back or from the codec model
  assign ac_sdin = loop_en ? ac_sdout : model_sdin;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: simulation ran past %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  always @(posedge clk_i) begin
    if (play_taken) begin
      taken_cnt <= taken_cnt + 1;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Codec model, MSB placed at the word clock edge so that the
  // receiver's sixteen sampling rises see the word in full
  always @(posedge clk_i) begin : codec_model
    logic [31:0]      r32;
    iis_pkg::sample_t word;
    prev_bclk <= ac_bclk;
    prev_lr   <= ac_lrclk;
    if (prev_bclk && !ac_bclk) begin
      if (prev_lr != ac_lrclk) begin
        word = '0;
        if (model_run) begin
          r32  = lfsr_bits(`IIS_DATA_SIZE);
          word = r32[`IIS_DATA_SIZE-1:0];
        end
        if (!ac_lrclk) begin
          model_l  <= word;
          model_hl <= model_run;
        end else if (model_hl && model_run) begin
          exp_q.push_back({model_l, word});
        end
        model_sdin <= word[`IIS_DATA_SIZE-1];
        model_sh   <= word << 1;
      end else begin
        model_sdin <= model_sh[`IIS_DATA_SIZE-1];
        model_sh   <= model_sh << 1;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Check failed: %s", what);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic write_pair(input iis_pkg::sample_t l, input iis_pkg::sample_t r);
    @(posedge clk_i);
    play_left  <= l;
    play_right <= r;
    play_valid <= 1'b1;
    @(posedge clk_i);
    play_valid <= 1'b0;
  endtask

  task automatic wait_taken();
    do @(negedge clk_i); while (!play_taken);
  endtask

  task automatic wait_rec();
    do @(negedge clk_i); while (!rec_valid);
  endtask

  task automatic wait_lr_fall();
    logic prev;
    prev = ac_lrclk;
    forever begin
      @(negedge clk_i);
      if (prev && !ac_lrclk) break;
      prev = ac_lrclk;
    end
  endtask

  // Called right after the word clock falls
  // Rises 2 to 17 carry left, 18 to 33 carry right
  task automatic decode_frame(output iis_pkg::sample_t l, output iis_pkg::sample_t r);
    int   n;
    logic prev;
    n    = 0;
    l    = '0;
    r    = '0;
    prev = ac_bclk;
    while (n < 33) begin
      @(negedge clk_i);
      if (!prev && ac_bclk) begin
        n++;
        if (n >= 2 && n <= 17) l = {l[`IIS_DATA_SIZE-2:0], ac_sdout};
        else if (n >= 18) r = {r[`IIS_DATA_SIZE-2:0], ac_sdout};
      end
      prev = ac_bclk;
    end
  endtask

  task automatic test_reset();
    repeat (4) begin
      @(negedge clk_i);
      check_value("reset", 32'd0,
                  {26'd0, ac_mclk, ac_bclk, ac_lrclk, ac_sdout, play_taken, rec_valid});
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("after_reset", 32'd0,
                {26'd0, ac_mclk, ac_bclk, ac_lrclk, ac_sdout, play_taken, rec_valid});
  endtask

  // Starts at the negedge right after reset release
  task automatic test_clock_ratios();
    logic [31:0] n;
    for (n = 1; n <= 1100; n++) begin
      @(negedge clk_i);
      check_value("clock_ratios", {29'd0, n[8], n[3], n[0]},
                  {29'd0, ac_lrclk, ac_bclk, ac_mclk});
    end
  endtask

  task automatic test_serial_format();
    logic [31:0]      r32;
    iis_pkg::sample_t l;
    iis_pkg::sample_t r;
    iis_pkg::sample_t got_l;
    iis_pkg::sample_t got_r;
    r32 = lfsr_bits(32);
    l   = r32[31:16];
    r   = r32[15:0];
    write_pair(l, r);
    wait_taken();
    decode_frame(got_l, got_r);
    check_value("serial_format_left", {16'd0, l}, {16'd0, got_l});
    check_value("serial_format_right", {16'd0, r}, {16'd0, got_r});
    last_right = r;
  endtask

  task automatic test_play_buffer();
    logic [31:0]      r32;
    iis_pkg::sample_t l;
    iis_pkg::sample_t r;
    iis_pkg::sample_t got_l;
    iis_pkg::sample_t got_r;
    int unsigned      cnt0;
    r32  = lfsr_bits(32);
    l    = r32[31:16];
    r    = r32[15:0];
    cnt0 = taken_cnt;
    write_pair(l, r);
    wait_taken();
    decode_frame(got_l, got_r);
    check_value("play_buffer_left", {16'd0, l}, {16'd0, got_l});
    check_value("play_buffer_right", {16'd0, r}, {16'd0, got_r});
    check_value("play_buffer_taken", cnt0 + 1, taken_cnt);
    // No new write, same pair repeats
    wait_lr_fall();
    decode_frame(got_l, got_r);
    check_value("play_buffer_repeat_left", {16'd0, l}, {16'd0, got_l});
    check_value("play_buffer_repeat_right", {16'd0, r}, {16'd0, got_r});
    check_value("play_buffer_no_taken", cnt0 + 1, taken_cnt);
    last_right = r;
  endtask

  task automatic test_recording();
    logic [31:0] exp_pair;
    exp_q.delete();
    @(posedge clk_i);
    model_run <= 1'b1;
    // Skip pairs of frames the model did not fill
    while (exp_q.size() == 0) @(negedge clk_i);
    for (int f = 0; f < 4; f++) begin
      wait_rec();
      check_true(exp_q.size() == 1, "rec_valid count does not match one per frame");
      exp_pair = exp_q.pop_front();
      check_value("recording", exp_pair, {rec_left, rec_right});
    end
    @(posedge clk_i);
    model_run <= 1'b0;
  endtask

  // Received word is the sent word one bit late across the half boundary
  task automatic test_loopback();
    logic [31:0]      r32;
    iis_pkg::sample_t l;
    iis_pkg::sample_t r;
    iis_pkg::sample_t exp_l;
    iis_pkg::sample_t exp_r;
    @(posedge clk_i);
    loop_en <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      r32 = lfsr_bits(32);
      l   = r32[31:16];
      r   = r32[15:0];
      write_pair(l, r);
      wait_taken();
      wait_rec();
      exp_l = {last_right[0], l[`IIS_DATA_SIZE-1:1]};
      exp_r = {l[0], r[`IIS_DATA_SIZE-1:1]};
      check_value("loopback", {exp_l, exp_r}, {rec_left, rec_right});
      last_right = r;
    end
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    play_valid = 1'b0;
    play_left  = '0;
    play_right = '0;
    loop_en    = 1'b0;
    model_run  = 1'b0;
    model_sdin = 1'b0;
    model_hl   = 1'b0;
    model_sh   = '0;
    model_l    = '0;
    prev_bclk  = 1'b0;
    prev_lr    = 1'b0;
    lfsr       = 32'h9a09_2cc8;
    cycles     = 0;
    taken_cnt  = 0;
    last_right = '0;
    test_reset();
    test_clock_ratios();
    test_serial_format();
    test_play_buffer();
    test_recording();
    test_loopback();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+common
common/iis_pkg.sv
logic/iis_clock_gen.sv
logic/iis_play_buffer.sv
iis_serdes/iis_tx_shift.sv
iis_serdes/iis_rx_shift.sv
logic/iis_rec_output.sv
logic/iis_codec_top.sv
tb/iis_codec_props.sv
tb/iis_codec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the I2S codec testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module iis_codec_tb -f list.f

./obj_dir/Viis_codec_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
